//--- design/fb_pkg.sv
/*
 * Shared definitions for the framebuffer scaler
 *   Pixel and address types, raster position types
 *   Source frame size and the fixed 640x480@60 modeline
 *   Window placement, scale factor and output pipeline latency
 */

`default_nettype none

package fb_pkg;

    // ----------------------------------------------------------------------
    // Source frame and memory
    // ----------------------------------------------------------------------
    localparam int PIX_W     = 8;                   // Bits per pixel
    localparam int SRC_W     = 160;                 // Source pixels per line
    localparam int SRC_H     = 120;                 // Source lines per frame
    localparam int ADDR_W    = 15;                  // Enough for SRC_W * SRC_H words
    localparam int FRAME_PIX = SRC_W * SRC_H;       // Words held by the frame memory

    typedef logic [PIX_W-1:0]  pixel_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [9:0]        hpos_t;              // Raster column, up to 1023
    typedef logic [9:0]        vpos_t;              // Raster line, up to 1023

    // ----------------------------------------------------------------------
    // VGA 640x480@60 modeline, negative sync on both axes
    // ----------------------------------------------------------------------
    localparam int H_ACTIVE     = 640;
    localparam int H_SYNC_START = 656;              // First column with hsync low
    localparam int H_SYNC_END   = 752;              // First column with hsync high again
    localparam int H_TOTAL      = 800;
    localparam int V_ACTIVE     = 480;
    localparam int V_SYNC_START = 490;
    localparam int V_SYNC_END   = 492;
    localparam int V_TOTAL      = 525;

    // Picture placement, the window is centred on the active area
    localparam int SCALE  = 2;                      // Repeat factor in both directions
    localparam int WIN_X0 = 160;
    localparam int WIN_Y0 = 120;
    localparam int WIN_X1 = WIN_X0 + SRC_W * SCALE; // First column past the window
    localparam int WIN_Y1 = WIN_Y0 + SRC_H * SCALE; // First line past the window

    // Scaler, memory and output register each add one cycle
    localparam int PIPE_LAT = 3;

endpackage

`default_nettype wire

//--- design/raster_if.sv
/*
 * Raster position bundle
 *   Column and line counts of the current cycle
 *   Raw active-low syncs and the blank flag
 *   Modports for the timing generator and its consumers
 */

`default_nettype none

interface raster_if;

    fb_pkg::hpos_t h_count;   // Current column, 0 to H_TOTAL-1
    fb_pkg::vpos_t v_count;   // Current line, 0 to V_TOTAL-1
    logic          h_sync_n;  // Low during the horizontal sync columns
    logic          v_sync_n;  // Low during the vertical sync lines
    logic          blank;     // High outside the active area

    modport timing_mp (output h_count, output v_count, output h_sync_n,
                       output v_sync_n, output blank);

    modport sink_mp (input h_count, input v_count, input h_sync_n,
                     input v_sync_n, input blank);

endinterface

`default_nettype wire

//--- design/pixel_capture.sv
/*
 * Input side of the framebuffer
 *   Column and row counters driven by the blank signals
 *   Hblank edge detector, frame bound check
 *   Registered memory write port
 */

`default_nettype none

module pixel_capture (
    input  wire logic           clk_vga,
    input  wire logic           i_rst_n,
    input  wire logic           i_pix_ce,   // Input pixel strobe
    input  wire logic           i_hblank,
    input  wire logic           i_vblank,
    input  wire fb_pkg::pixel_t i_rgb,
    output logic                o_wr_en,
    output fb_pkg::addr_t       o_wr_addr,
    output fb_pkg::pixel_t      o_wr_data
);

    fb_pkg::hpos_t col_cnt;    // Active pixels since hblank, stops at SRC_W
    fb_pkg::vpos_t row_cnt;    // Hblank rising edges since vblank, stops at SRC_H
    logic          hblank_d;   // Hblank seen on the previous strobed cycle
    logic          pix_active;
    logic          in_frame;

    assign pix_active = !i_hblank && !i_vblank;  // Both blanks low means a visible pixel
    assign in_frame   = (col_cnt < fb_pkg::SRC_W) && (row_cnt < fb_pkg::SRC_H);

    // ----------------------------------------------------------------------
    // Counters, they only move on strobed cycles
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_vga) begin
        if (!i_rst_n) begin
            col_cnt  <= '0;
            row_cnt  <= '0;
            hblank_d <= 1'b0;
        end else if (i_pix_ce) begin
            hblank_d <= i_hblank;
            if (i_hblank) begin
                col_cnt <= '0;                    // Next line starts at column 0
            end else if (pix_active && col_cnt != fb_pkg::SRC_W) begin
                col_cnt <= col_cnt + 1'b1;        // Saturates so long lines fall outside
            end
            // Vblank holds the row at 0 and wins over a coincident edge
            if (i_vblank) begin
                row_cnt <= '0;
            end else if (i_hblank && !hblank_d && row_cnt != fb_pkg::SRC_H) begin
                row_cnt <= row_cnt + 1'b1;        // A line just ended
            end
        end
    end

    // Write strobe, one cycle after the sampled pixel
    always_ff @(posedge clk_vga) begin
        if (!i_rst_n) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= i_pix_ce && pix_active && in_frame;
        end
    end

    // Address and data travel with the strobe, the strobe alone qualifies them
    always_ff @(posedge clk_vga) begin
        o_wr_addr <= fb_pkg::addr_t'(row_cnt * fb_pkg::SRC_W + col_cnt);
        o_wr_data <= i_rgb;
    end

endmodule

`default_nettype wire

//--- design/frame_ram.sv
/*
 * Frame memory
 *   One write port and one read port on clk_vga
 *   Registered read, old data on a same-address collision
 */

`default_nettype none

module frame_ram (
    input  wire logic           clk_vga,
    input  wire logic           i_wr_en,
    input  wire fb_pkg::addr_t  i_wr_addr,
    input  wire fb_pkg::pixel_t i_wr_data,
    input  wire fb_pkg::addr_t  i_rd_addr,
    output fb_pkg::pixel_t      o_rd_data
);

    // One word per source pixel, row major
    fb_pkg::pixel_t mem [fb_pkg::FRAME_PIX];

    always_ff @(posedge clk_vga) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Read data is valid one cycle after the address
    always_ff @(posedge clk_vga) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

//--- design/raster_timing.sv
/*
 * VGA timing generator
 *   Column and line counters over the 640x480@60 modeline
 *   Decode of the active-low syncs and the blank flag
 */

`default_nettype none

module raster_timing (
    input  wire logic clk_vga,
    input  wire logic i_rst_n,
    raster_if.timing_mp rast
);

    fb_pkg::hpos_t h_cnt;
    fb_pkg::vpos_t v_cnt;
    logic          h_last;   // Last column of the line
    logic          v_last;   // Last line of the frame

    assign h_last = (h_cnt == fb_pkg::hpos_t'(fb_pkg::H_TOTAL - 1));
    assign v_last = (v_cnt == fb_pkg::vpos_t'(fb_pkg::V_TOTAL - 1));

    // ----------------------------------------------------------------------
    // Position counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_vga) begin
        if (!i_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;                          // Column wraps, line moves on
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Decode of the current position
    // ----------------------------------------------------------------------
    assign rast.h_count  = h_cnt;
    assign rast.v_count  = v_cnt;
    assign rast.h_sync_n = !((h_cnt >= fb_pkg::H_SYNC_START) &&
                             (h_cnt <  fb_pkg::H_SYNC_END));   // Low for columns 656 to 751
    assign rast.v_sync_n = !((v_cnt >= fb_pkg::V_SYNC_START) &&
                             (v_cnt <  fb_pkg::V_SYNC_END));   // Low for lines 490 and 491
    assign rast.blank    = (h_cnt >= fb_pkg::H_ACTIVE) || (v_cnt >= fb_pkg::V_ACTIVE);

endmodule

`default_nettype wire

//--- design/window_scaler.sv
/*
 * Window scaler
 *   Source column and row counters with integer scale counters
 *   Memory read address and in-window flag, one registered cycle
 */

`default_nettype none

module window_scaler (
    input  wire logic     clk_vga,
    input  wire logic     i_rst_n,
    raster_if.sink_mp     rast,
    output fb_pkg::addr_t o_rd_addr,
    output logic          o_in_window
);

    localparam int SC_W = $clog2(fb_pkg::SCALE + 1);

    // Registered state belongs to the previous column or line
    fb_pkg::hpos_t   col_reg;
    fb_pkg::vpos_t   row_reg;
    logic [SC_W-1:0] hsc_reg;
    logic [SC_W-1:0] vsc_reg;

    // Values that belong to the current raster position
    fb_pkg::hpos_t   col_now;
    fb_pkg::vpos_t   row_now;
    logic [SC_W-1:0] hsc_now;
    logic [SC_W-1:0] vsc_now;
    logic            in_win_now;

    // ----------------------------------------------------------------------
    // Scale counting, restart at the window's top-left corner
    // ----------------------------------------------------------------------
    always_comb begin
        if (rast.h_count == fb_pkg::WIN_X0) begin
            col_now = '0;                          // First window column
            hsc_now = '0;
        end else if (hsc_reg == fb_pkg::SCALE - 1) begin
            col_now = col_reg + 1'b1;              // Source column repeated SCALE times
            hsc_now = '0;
        end else begin
            col_now = col_reg;
            hsc_now = hsc_reg + 1'b1;
        end

        // Rows only move on the first column of a line
        row_now = row_reg;
        vsc_now = vsc_reg;
        if (rast.h_count == '0) begin
            if (rast.v_count == fb_pkg::WIN_Y0) begin
                row_now = '0;
                vsc_now = '0;
            end else if (vsc_reg == fb_pkg::SCALE - 1) begin
                row_now = row_reg + 1'b1;
                vsc_now = '0;
            end else begin
                vsc_now = vsc_reg + 1'b1;
            end
        end
    end

    assign in_win_now = (rast.h_count >= fb_pkg::WIN_X0) && (rast.h_count < fb_pkg::WIN_X1) &&
                        (rast.v_count >= fb_pkg::WIN_Y0) && (rast.v_count < fb_pkg::WIN_Y1);

    always_ff @(posedge clk_vga) begin
        if (!i_rst_n) begin
            col_reg     <= '0;
            row_reg     <= '0;
            hsc_reg     <= '0;
            vsc_reg     <= '0;
            o_in_window <= 1'b0;
        end else begin
            col_reg     <= col_now;
            row_reg     <= row_now;
            hsc_reg     <= hsc_now;
            vsc_reg     <= vsc_now;
            o_in_window <= in_win_now;
        end
    end

    // Outside the window the address parks at 0 so the read stays in range
    always_ff @(posedge clk_vga) begin
        o_rd_addr <= in_win_now ? fb_pkg::addr_t'(row_now * fb_pkg::SRC_W + col_now) : '0;
    end

endmodule

`default_nettype wire

//--- design/video_out.sv
/*
 * Output stage
 *   Delay lines for the syncs, blank and odd-line flag
 *   Window flag aligned with the memory data
 *   Registered pixel, black outside the window
 */

`default_nettype none

module video_out (
    input  wire logic           clk_vga,
    input  wire logic           i_rst_n,
    raster_if.sink_mp           rast,
    input  wire fb_pkg::pixel_t i_rd_data,
    input  wire logic           i_in_window,
    output fb_pkg::pixel_t      o_rgb,
    output logic                o_hsync_n,
    output logic                o_vsync_n,
    output logic                o_blank,
    output logic                o_odd_line
);

    localparam int LAT = fb_pkg::PIPE_LAT;

    // Bit 0 holds the newest sample, the top bit drives the port
    logic [LAT-1:0] hs_pipe;
    logic [LAT-1:0] vs_pipe;
    logic [LAT-1:0] blank_pipe;
    logic [LAT-1:0] odd_pipe;
    logic           in_window_d;   // Window flag in step with i_rd_data

    // ----------------------------------------------------------------------
    // Control delay lines
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_vga) begin
        if (!i_rst_n) begin
            hs_pipe    <= '1;                      // Syncs idle high
            vs_pipe    <= '1;
            blank_pipe <= '1;                      // Blanked until the pipe fills
            odd_pipe   <= '0;
        end else begin
            hs_pipe    <= {hs_pipe[LAT-2:0], rast.h_sync_n};
            vs_pipe    <= {vs_pipe[LAT-2:0], rast.v_sync_n};
            blank_pipe <= {blank_pipe[LAT-2:0], rast.blank};
            odd_pipe   <= {odd_pipe[LAT-2:0], rast.v_count[0]};
        end
    end

    // ----------------------------------------------------------------------
    // Pixel path
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_vga) begin
        if (!i_rst_n) begin
            in_window_d <= 1'b0;
            o_rgb       <= '0;
        end else begin
            in_window_d <= i_in_window;
            o_rgb       <= in_window_d ? i_rd_data : '0;  // Black border around the picture
        end
    end

    assign o_hsync_n  = hs_pipe[LAT-1];
    assign o_vsync_n  = vs_pipe[LAT-1];
    assign o_blank    = blank_pipe[LAT-1];
    assign o_odd_line = odd_pipe[LAT-1];

endmodule

`default_nettype wire

//--- design/fb_scaler_top.sv
/*
 * Framebuffer scaler top level
 *   Input capture and frame memory
 *   VGA timing, window scaler and output stage
 */

`default_nettype none

module fb_scaler_top (
    input  wire logic           clk_vga,
    input  wire logic           i_rst_n,
    // Source video
    input  wire logic           i_pix_ce,
    input  wire logic           i_hblank,
    input  wire logic           i_vblank,
    input  wire fb_pkg::pixel_t i_rgb,
    // VGA output
    output fb_pkg::pixel_t      o_rgb,
    output logic                o_hsync_n,
    output logic                o_vsync_n,
    output logic                o_blank,
    output logic                o_odd_line
);

    logic           wr_en;
    fb_pkg::addr_t  wr_addr;
    fb_pkg::pixel_t wr_data;
    fb_pkg::addr_t  rd_addr;
    fb_pkg::pixel_t rd_data;
    logic           in_window;

    raster_if rast ();

    // ----------------------------------------------------------------------
    // Write side
    // ----------------------------------------------------------------------
    pixel_capture u_capture (
        .clk_vga   (clk_vga),
        .i_rst_n   (i_rst_n),
        .i_pix_ce  (i_pix_ce),
        .i_hblank  (i_hblank),
        .i_vblank  (i_vblank),
        .i_rgb     (i_rgb),
        .o_wr_en   (wr_en),
        .o_wr_addr (wr_addr),
        .o_wr_data (wr_data)
    );

    frame_ram u_ram (
        .clk_vga   (clk_vga),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    // ----------------------------------------------------------------------
    // Read side
    // ----------------------------------------------------------------------
    raster_timing u_timing (
        .clk_vga (clk_vga),
        .i_rst_n (i_rst_n),
        .rast    (rast.timing_mp)
    );

    window_scaler u_scaler (
        .clk_vga     (clk_vga),
        .i_rst_n     (i_rst_n),
        .rast        (rast.sink_mp),
        .o_rd_addr   (rd_addr),
        .o_in_window (in_window)
    );

    video_out u_out (
        .clk_vga     (clk_vga),
        .i_rst_n     (i_rst_n),
        .rast        (rast.sink_mp),
        .i_rd_data   (rd_data),
        .i_in_window (in_window),
        .o_rgb       (o_rgb),
        .o_hsync_n   (o_hsync_n),
        .o_vsync_n   (o_vsync_n),
        .o_blank     (o_blank),
        .o_odd_line  (o_odd_line)
    );

endmodule

`default_nettype wire

//--- test/fb_scaler_assert.sv
/*
 * Concurrent checks on the framebuffer scaler
 *   Black pixel during blank, output hsync pulse width
 *   Write address inside the frame memory
 */

`default_nettype none

module fb_scaler_assert (
    input wire logic           clk_vga,
    input wire logic           i_rst_n,
    input wire fb_pkg::pixel_t i_out_rgb,
    input wire logic           i_out_blank,
    input wire logic           i_out_hsync_n,
    input wire logic           i_wr_en,
    input wire fb_pkg::addr_t  i_wr_addr
);

    localparam int HS_WIDTH = fb_pkg::H_SYNC_END - fb_pkg::H_SYNC_START;

    logic [7:0] hs_low_cnt;   // Low samples of the output hsync so far in this pulse

    always_ff @(posedge clk_vga) begin
        if (!i_rst_n) begin
            hs_low_cnt <= '0;
        end else if (!i_out_hsync_n) begin
            hs_low_cnt <= hs_low_cnt + 1'b1;
        end else begin
            hs_low_cnt <= '0;
        end
    end

    a_black_in_blank: assert property (@(posedge clk_vga) disable iff (!i_rst_n)
        i_out_blank |-> (i_out_rgb == '0))
        else $error("o_rgb is not black while o_blank is high");

    // A pulse may not run past its width, and must reach it before sync returns
    a_hsync_not_long: assert property (@(posedge clk_vga) disable iff (!i_rst_n)
        !i_out_hsync_n |-> (hs_low_cnt < HS_WIDTH))
        else $error("o_hsync_n low pulse is too long");

    a_hsync_width: assert property (@(posedge clk_vga) disable iff (!i_rst_n)
        $rose(i_out_hsync_n) |-> (hs_low_cnt == HS_WIDTH))
        else $error("o_hsync_n low pulse is too short");

    a_wr_addr_range: assert property (@(posedge clk_vga) disable iff (!i_rst_n)
        i_wr_en |-> (i_wr_addr < fb_pkg::FRAME_PIX))
        else $error("Frame memory write address out of range");

endmodule

bind fb_scaler_top fb_scaler_assert u_assert (
    .clk_vga       (clk_vga),
    .i_rst_n       (i_rst_n),
    .i_out_rgb     (o_rgb),
    .i_out_blank   (o_blank),
    .i_out_hsync_n (o_hsync_n),
    .i_wr_en       (wr_en),
    .i_wr_addr     (wr_addr)
);

`default_nettype wire

//--- test/tb_fb_scaler.sv
/*
 * Testbench for the framebuffer scaler
 *   Frame table applied in a loop, LFSR picture source
 *   Source video driver with a selectable strobe spacing
 *   Raster checker for syncs, blank, odd line and the scaled picture
 */

`default_nettype none

module tb_fb_scaler;

    localparam int          RST_CYCLES = 8;
    localparam int          HBLANK_LEN = 20;             // Strobed hblank cycles after each line
    localparam int          VBL_PRE    = 2;              // Vblank lines ahead of the picture
    localparam int          VBL_POST   = 2;              // Vblank lines after it
    localparam logic [31:0] LFSR_SEED  = 32'hcfb6_ac0b;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    localparam int          FRAME_CYC  = fb_pkg::H_TOTAL * fb_pkg::V_TOTAL;
    localparam int          VS_TIMEOUT = 2 * FRAME_CYC;
    localparam int          N_ROWS     = 4;

    typedef struct packed {
        logic [1:0] spacing;   // Clock cycles from one strobe to the next
        logic       fresh;     // New random picture before sending
        logic       check;     // Check the output frame that follows
    } frame_row_t;

    logic           clk_vga;
    logic           i_rst_n;
    logic           i_pix_ce;
    logic           i_hblank;
    logic           i_vblank;
    fb_pkg::pixel_t i_rgb;
    fb_pkg::pixel_t o_rgb;
    logic           o_hsync_n;
    logic           o_vsync_n;
    logic           o_blank;
    logic           o_odd_line;

    fb_pkg::pixel_t model [fb_pkg::SRC_H][fb_pkg::SRC_W];  // Picture the memory should hold
    frame_row_t     frame_tab [N_ROWS];
    logic [31:0]    lfsr;

    fb_scaler_top UUT (
        .clk_vga    (clk_vga),
        .i_rst_n    (i_rst_n),
        .i_pix_ce   (i_pix_ce),
        .i_hblank   (i_hblank),
        .i_vblank   (i_vblank),
        .i_rgb      (i_rgb),
        .o_rgb      (o_rgb),
        .o_hsync_n  (o_hsync_n),
        .o_vsync_n  (o_vsync_n),
        .o_blank    (o_blank),
        .o_odd_line (o_odd_line)
    );

    always #50 clk_vga = ~clk_vga;

    // ----------------------------------------------------------------------
    // Random source and failure handling
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per pixel bit, MSB first
    task automatic fill_picture();
        fb_pkg::pixel_t px;
        for (int y = 0; y < fb_pkg::SRC_H; y++) begin
            for (int x = 0; x < fb_pkg::SRC_W; x++) begin
                px = '0;
                for (int b = 0; b < fb_pkg::PIX_W; b++) begin
                    lfsr = lfsr_next(lfsr);
                    px   = {px[fb_pkg::PIX_W-2:0], lfsr[0]};
                end
                model[y][x] = px;
            end
        end
    endtask

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_pixel(input string name, input fb_pkg::pixel_t exp,
                               input fb_pkg::pixel_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Outputs while the pipeline is still empty
    task automatic check_idle();
        check_bit("o_hsync_n", 1'b1, o_hsync_n);
        check_bit("o_vsync_n", 1'b1, o_vsync_n);
        check_bit("o_blank", 1'b1, o_blank);
        check_bit("o_odd_line", 1'b0, o_odd_line);
        check_pixel("o_rgb", '0, o_rgb);
    endtask

    // ----------------------------------------------------------------------
    // Source video driver
    // ----------------------------------------------------------------------
    task automatic send_cycle(input logic hb, input logic vb, input fb_pkg::pixel_t data,
                              input int spacing);
        @(posedge clk_vga);
        i_pix_ce <= 1'b1;
        i_hblank <= hb;
        i_vblank <= vb;
        i_rgb    <= data;
        repeat (spacing - 1) begin
            @(posedge clk_vga);
            i_pix_ce <= 1'b0;
            i_hblank <= !hb;                             // Gap cycles carry junk the capture ignores
            i_vblank <= !vb;
            i_rgb    <= ~data;
        end
    endtask

    task automatic send_line(input logic vb, input int y, input int spacing);
        fb_pkg::pixel_t junk;
        junk = '1;
        for (int x = 0; x < fb_pkg::SRC_W; x++) begin
            if (vb) begin
                send_cycle(1'b0, 1'b1, junk, spacing);   // Must never reach the memory
            end else begin
                send_cycle(1'b0, 1'b0, model[y][x], spacing);
            end
        end
        repeat (HBLANK_LEN) begin
            send_cycle(1'b1, vb, junk, spacing);
        end
    endtask

    task automatic send_frame(input int spacing);
        repeat (VBL_PRE) begin
            send_line(1'b1, 0, spacing);
        end
        for (int y = 0; y < fb_pkg::SRC_H; y++) begin
            send_line(1'b0, y, spacing);
        end
        repeat (VBL_POST) begin
            send_line(1'b1, 0, spacing);
        end
        @(posedge clk_vga);
        i_pix_ce <= 1'b0;                                // Source goes quiet between frames
        i_hblank <= 1'b1;
        i_vblank <= 1'b1;
    endtask

    // ----------------------------------------------------------------------
    // Raster checker, samples on the falling edge
    // ----------------------------------------------------------------------
    task automatic wait_vsync_fall();
        int   n;
        logic prev;
        logic seen;
        n    = 0;
        prev = 1'b0;
        seen = 1'b0;
        while (!seen && n < VS_TIMEOUT) begin
            @(negedge clk_vga);
            seen = prev && !o_vsync_n;
            prev = o_vsync_n;
            n++;
        end
        if (!seen) begin
            $display("Timeout, the output vertical sync never started a new frame");
            abort_run();
        end
    endtask

    // Starts on the first sample with vsync low, that is column 0 of line V_SYNC_START
    task automatic check_frame();
        int             col;
        int             line;
        logic           in_win;
        fb_pkg::pixel_t exp_rgb;
        col  = 0;
        line = fb_pkg::V_SYNC_START;
        for (int k = 0; k < FRAME_CYC; k++) begin
            if (k != 0) begin
                @(negedge clk_vga);
            end
            in_win = (col >= fb_pkg::WIN_X0) && (col < fb_pkg::WIN_X0 + fb_pkg::SRC_W * 2) &&
                     (line >= fb_pkg::WIN_Y0) && (line < fb_pkg::WIN_Y0 + fb_pkg::SRC_H * 2);
            if (in_win) begin
                exp_rgb = model[(line - fb_pkg::WIN_Y0) / 2][(col - fb_pkg::WIN_X0) / 2];
            end else begin
                exp_rgb = '0;                            // Black border and blanking
            end
            check_bit("o_hsync_n", !(col >= 656 && col < 752), o_hsync_n);
            check_bit("o_vsync_n", !(line >= 490 && line < 492), o_vsync_n);
            check_bit("o_blank", (col >= 640) || (line >= 480), o_blank);
            check_bit("o_odd_line", (line % 2) == 1, o_odd_line);
            check_pixel("o_rgb", exp_rgb, o_rgb);
            col++;
            if (col == fb_pkg::H_TOTAL) begin
                col  = 0;
                line = (line + 1) % fb_pkg::V_TOTAL;     // Wraps from the last line to line 0
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        clk_vga  = 1'b0;
        i_rst_n  = 1'b0;
        i_pix_ce = 1'b0;
        i_hblank = 1'b1;
        i_vblank = 1'b1;
        i_rgb    = '0;
        lfsr     = LFSR_SEED;

        // Spacing 1, spacing 3, a repeat that is not checked, then a new picture on top
        frame_tab[0] = '{spacing: 2'd1, fresh: 1'b1, check: 1'b1};
        frame_tab[1] = '{spacing: 2'd3, fresh: 1'b1, check: 1'b1};
        frame_tab[2] = '{spacing: 2'd3, fresh: 1'b0, check: 1'b0};
        frame_tab[3] = '{spacing: 2'd1, fresh: 1'b1, check: 1'b1};

        repeat (RST_CYCLES - 1) begin
            @(posedge clk_vga);
            @(negedge clk_vga);
            check_idle();
        end
        @(posedge clk_vga);
        i_rst_n <= 1'b1;                                 // Last edge that still sees reset
        repeat (fb_pkg::PIPE_LAT) begin
            @(negedge clk_vga);
            check_idle();                                // Pipeline still filling
            @(posedge clk_vga);
        end

        for (int i = 0; i < N_ROWS; i++) begin
            if (frame_tab[i].fresh) begin
                fill_picture();
            end
            send_frame(frame_tab[i].spacing);
            if (frame_tab[i].check) begin
                wait_vsync_fall();
                check_frame();
            end
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/fb_pkg.sv
design/raster_if.sv
design/pixel_capture.sv
design/frame_ram.sv
design/raster_timing.sv
design/window_scaler.sv
design/video_out.sv
design/fb_scaler_top.sv
test/fb_scaler_assert.sv
test/tb_fb_scaler.sv

//--- run.sh
#!/bin/sh
# Builds the framebuffer scaler testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fb_scaler -f build.f \
    && ./obj_dir/Vtb_fb_scaler > sim.log 2>&1

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
